// ==== tb.f ====
+incdir+hw
hw/dsp_pkg.sv
hw/delay_buffer.sv
hw/comb_ffe.sv
hw/comb_comp.sv
hw/channel_filter.sv
hw/sliding_detector.sv
hw/datapath_core.sv
dv/tb_datapath_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f \
    --top-module tb_datapath_core -o sim_tb_datapath_core

out=$(./obj_dir/sim_tb_datapath_core)
echo "$out"

# The run counts as passing only if the pass line was printed
echo "$out" | grep -qx "sim passed"

// ==== dv/tb_datapath_core.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module tb_datapath_core;

    localparam int lanes   = `DSP_CHANNEL_WIDTH;
    localparam int ffe_len = `DSP_FFE_LENGTH;
    localparam int depth   = `DSP_CHANNEL_DEPTH;
    localparam int seq_len = `DSP_SEQ_LENGTH;
    // Stream words of all tests, and one 4-word flush per configuration
    localparam int total_words    = 620;
    localparam int num_flush      = 8;
    localparam int timeout_cycles = 6 * (total_words + 4 * num_flush);
    localparam int max_cyc        = total_words + 4 * num_flush + 8;
    // Words of zero history ahead of word 0
    localparam int off    = 4;
    localparam int flat_n = (max_cyc + off) * lanes;

    logic              clk;
    logic              rst_n;
    dsp_pkg::code_t    adc_codes   [lanes-1:0];
    dsp_pkg::weight_t  weights     [ffe_len-1:0][lanes-1:0];
    logic              dis_product [ffe_len-1:0][lanes-1:0];
    logic [`DSP_FFE_SHIFT_PRECISION-1:0]  ffe_shift [lanes-1:0];
    dsp_pkg::ffe_est_t thresh      [lanes-1:0];
    dsp_pkg::tap_t     taps        [lanes-1:0][depth-1:0];
    logic [`DSP_CHAN_SHIFT_PRECISION-1:0] chan_shift [lanes-1:0];
    logic              bits_o      [lanes-1:0];
    dsp_pkg::error_t   est_error_o [lanes-1:0];
    logic [1:0]        err_pos_o   [lanes-1:0];

    // Model history as one flat lane stream, lane index = (word + off) * lanes + lane
    dsp_pkg::code_t  code_f [flat_n];
    logic            bit_f  [flat_n];
    dsp_pkg::error_t err_f  [flat_n];
    logic            exp_bits [max_cyc][lanes];
    dsp_pkg::error_t exp_err  [max_cyc][lanes];
    logic [1:0]      exp_pos  [max_cyc][lanes];

    int cycle;
    int ticks;
    int exp_top;
    int checks;
    int bit_errs;
    int err_errs;
    int pos_errs;

    datapath_core dut (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .adc_codes_i       (adc_codes),
        .weights_i         (weights),
        .disable_product_i (dis_product),
        .ffe_shift_i       (ffe_shift),
        .thresh_i          (thresh),
        .channel_est_i     (taps),
        .channel_shift_i   (chan_shift),
        .bits_o            (bits_o),
        .est_error_o       (est_error_o),
        .err_pos_o         (err_pos_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        ticks <= ticks + 1;
        if (rst_n) begin
            cycle <= cycle + 1;
        end
        if (ticks >= timeout_cycles) begin
            $display("TIMEOUT: run did not finish within %0d cycles, DUT or stimulus hangs",
                     timeout_cycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic dsp_pkg::ffe_est_t ffe_model(int g);
        longint acc;
        int     i;
        acc = 0;
        i   = g % lanes;
        for (int k = 0; k < ffe_len; k++) begin
            if (!dis_product[k][i]) begin
                acc += longint'(weights[k][i]) * longint'(code_f[g-k]);
            end
        end
        return dsp_pkg::ffe_est_t'(acc >>> ffe_shift[i]);
    endfunction

    function automatic logic slice_model(dsp_pkg::ffe_est_t est, int i);
        return est >= thresh[i];
    endfunction

    // Bit 1 maps to +1 and bit 0 to -1
    function automatic dsp_pkg::est_code_t chan_model(int g);
        longint acc;
        int     i;
        acc = 0;
        i   = g % lanes;
        for (int k = 0; k < depth; k++) begin
            acc += bit_f[g-k] ? longint'(taps[i][k]) : -longint'(taps[i][k]);
        end
        return dsp_pkg::est_code_t'(acc >>> chan_shift[i]);
    endfunction

    function automatic logic [1:0] detect_model(int g);
        longint adj;
        longint cost;
        longint best_cost;
        int     best;
        best      = 0;
        best_cost = 0;
        for (int c = 0; c < 3; c++) begin
            cost = 0;
            for (int j = g; j < g + seq_len; j++) begin
                adj = err_f[j];
                for (int m = g; m < g + c; m++) begin
                    if (j >= m && j - m < depth) begin
                        adj -= (bit_f[m] ? 2 : -2) * longint'(taps[j % lanes][j-m]);
                    end
                end
                cost += adj * adj;
            end
            if (c == 0 || cost < best_cost) begin
                best_cost = cost;
                best      = c;
            end
        end
        return 2'(best);
    endfunction

    // Applies adc_codes as word number cycle and books what the next edge must show
    task automatic drive_word();
        int b;
        b = (cycle + off) * lanes;
        for (int i = 0; i < lanes; i++) begin
            code_f[b+i] = adc_codes[i];
        end
        for (int i = 0; i < lanes; i++) begin
            bit_f[b+i] = slice_model(ffe_model(b + i), i);
            exp_bits[cycle+1][i] = bit_f[b+i];
            err_f[b-lanes+i] = dsp_pkg::error_t'(int'(chan_model(b - lanes + i))
                                                 - int'(code_f[b-lanes+i]));
            exp_err[cycle+1][i] = err_f[b-lanes+i];
        end
        for (int i = 0; i < lanes; i++) begin
            exp_pos[cycle+1][i] = detect_model(b - 3 * lanes + i);
        end
        exp_top = cycle + 1;
        @(posedge clk);
        #10;
    endtask

    task automatic flush_pipeline();
        adc_codes = '{default: '0};
        repeat (4) drive_word();
    endtask

    task automatic run_random(int n);
        repeat (n) begin
            for (int i = 0; i < lanes; i++) begin
                adc_codes[i] = dsp_pkg::code_t'($urandom);
            end
            drive_word();
        end
    endtask

    // Codes are the channel output of random bits, optionally one lane pushed off
    task automatic run_clean(int n, bit push);
        int b;
        int lane;
        repeat (n) begin
            b = (cycle + off) * lanes;
            for (int i = 0; i < lanes; i++) begin
                bit_f[b+i]   = 1'($urandom);
                adc_codes[i] = dsp_pkg::code_t'(chan_model(b + i));
            end
            if (push) begin
                lane = int'($urandom % lanes);
                adc_codes[lane] = dsp_pkg::code_t'((adc_codes[lane] < 0) ?
                    int'(adc_codes[lane]) + 100 : int'(adc_codes[lane]) - 100);
            end
            drive_word();
        end
    endtask

    task automatic set_identity();
        weights     = '{default: '0};
        dis_product = '{default: '0};
        thresh      = '{default: '0};
        for (int i = 0; i < lanes; i++) begin
            weights[0][i] = 8'sd64;
            ffe_shift[i]  = 4'd6;
        end
    endtask

    task automatic randomize_ffe();
        for (int i = 0; i < lanes; i++) begin
            for (int k = 0; k < ffe_len; k++) begin
                weights[k][i]     = dsp_pkg::weight_t'($urandom);
                dis_product[k][i] = 1'($urandom);
            end
            ffe_shift[i] = 4'($urandom % 12);
            thresh[i]    = dsp_pkg::ffe_est_t'(int'($urandom % 41) - 20);
        end
    endtask

    // A dominant main tap keeps the slicer on the transmitted bit
    task automatic randomize_chan(bit dominant);
        for (int i = 0; i < lanes; i++) begin
            taps[i][0] = dominant ? dsp_pkg::tap_t'(40 + $urandom % 20)
                                  : dsp_pkg::tap_t'($urandom);
            for (int k = 1; k < depth; k++) begin
                taps[i][k] = dominant ? dsp_pkg::tap_t'(int'($urandom % 21) - 10)
                                      : dsp_pkg::tap_t'($urandom);
            end
            chan_shift[i] = dominant ? 3'($urandom % 2) : 3'($urandom);
        end
    endtask

    always @(negedge clk) begin
        if (cycle <= exp_top) begin
            for (int i = 0; i < lanes; i++) begin
                checks++;
                if (bits_o[i] !== exp_bits[cycle][i]) begin
                    bit_errs++;
                    $display("ERROR at %0t: bits_o[%0d] expected %0d, actual %0d",
                             $time, i, exp_bits[cycle][i], bits_o[i]);
                end
                if (est_error_o[i] !== exp_err[cycle][i]) begin
                    err_errs++;
                    $display("ERROR at %0t: est_error_o[%0d] expected %0d, actual %0d",
                             $time, i, exp_err[cycle][i], est_error_o[i]);
                end
                if (err_pos_o[i] !== exp_pos[cycle][i]) begin
                    pos_errs++;
                    $display("ERROR at %0t: err_pos_o[%0d] expected %0d, actual %0d",
                             $time, i, exp_pos[cycle][i], err_pos_o[i]);
                end
            end
        end
    end

    initial begin
        void'($urandom(13));
        rst_n       = 1'b0;
        adc_codes   = '{default: '0};
        weights     = '{default: '0};
        dis_product = '{default: '0};
        ffe_shift   = '{default: '0};
        thresh      = '{default: '0};
        taps        = '{default: '0};
        chan_shift  = '{default: '0};
        code_f      = '{default: '0};
        bit_f       = '{default: '0};
        err_f       = '{default: '0};
        exp_bits    = '{default: '0};
        exp_err     = '{default: '0};
        exp_pos     = '{default: '0};
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;

        set_identity();
        randomize_chan(1'b1);
        flush_pipeline();
        run_random(50);
        randomize_ffe();
        flush_pipeline();
        run_random(200);
        set_identity();
        randomize_chan(1'b0);
        flush_pipeline();
        run_random(100);
        randomize_chan(1'b1);
        flush_pipeline();
        run_clean(50, 1'b0);
        run_clean(100, 1'b1);
        repeat (3) begin
            randomize_ffe();
            randomize_chan(1'b0);
            flush_pipeline();
            run_random(40);
        end
        // Drain so the last patterns reach err_pos_o
        flush_pipeline();
        @(negedge clk);
        #5;

        $display("checks %0d, errors: bits_o %0d, est_error_o %0d, err_pos_o %0d",
                 checks, bit_errs, err_errs, pos_errs);
        if (bit_errs + err_errs + pos_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_datapath_core

// ==== hw/datapath_core.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module datapath_core (
    input  logic              clk,
    input  logic              rst_n_i,
    input  dsp_pkg::code_t    adc_codes_i       [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::weight_t  weights_i         [`DSP_FFE_LENGTH-1:0][`DSP_CHANNEL_WIDTH-1:0],
    input  logic              disable_product_i [`DSP_FFE_LENGTH-1:0][`DSP_CHANNEL_WIDTH-1:0],
    input  logic [`DSP_FFE_SHIFT_PRECISION-1:0]  ffe_shift_i     [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::ffe_est_t thresh_i          [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::tap_t     channel_est_i     [`DSP_CHANNEL_WIDTH-1:0][`DSP_CHANNEL_DEPTH-1:0],
    input  logic [`DSP_CHAN_SHIFT_PRECISION-1:0] channel_shift_i [`DSP_CHANNEL_WIDTH-1:0],
    output logic              bits_o            [`DSP_CHANNEL_WIDTH-1:0],
    output dsp_pkg::error_t   est_error_o       [`DSP_CHANNEL_WIDTH-1:0],
    output logic [1:0]        err_pos_o         [`DSP_CHANNEL_WIDTH-1:0]
);

    localparam integer lanes      = `DSP_CHANNEL_WIDTH;
    localparam integer code_w     = `DSP_CODE_PRECISION;
    localparam integer err_w      = `DSP_ERROR_PRECISION;
    localparam integer code_depth = 1;
    localparam integer bit_depth  = 3;
    localparam integer err_depth  = 1;

    // Raw buffer views, signed types are restored below
    logic [code_w-1:0] code_u   [lanes-1:0];
    logic [code_w-1:0] code_buf [lanes-1:0][code_depth:0];
    logic [0:0]        bit_u    [lanes-1:0];
    logic [0:0]        bit_buf  [lanes-1:0][bit_depth:0];
    logic [err_w-1:0]  err_u    [lanes-1:0];
    logic [err_w-1:0]  err_buf  [lanes-1:0][err_depth:0];

    dsp_pkg::code_t     prev_codes [lanes-1:0];
    dsp_pkg::ffe_est_t  estimate   [lanes-1:0];
    logic               bits_d1    [lanes-1:0];
    logic               bits_d2    [lanes-1:0];
    dsp_pkg::est_code_t est_code   [lanes-1:0];
    dsp_pkg::error_t    err_next   [lanes-1:0];
    dsp_pkg::error_t    prev_err   [lanes-1:0];

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            code_u[i]     = adc_codes_i[i];
            prev_codes[i] = dsp_pkg::code_t'(code_buf[i][1]);
            bit_u[i]      = bits_o[i];
            bits_d1[i]    = bit_buf[i][1][0];
            bits_d2[i]    = bit_buf[i][2][0];
            err_u[i]      = est_error_o[i];
            prev_err[i]   = dsp_pkg::error_t'(err_buf[i][1]);
        end
    end

    delay_buffer #(
        .lanes    (lanes),
        .bitwidth (code_w),
        .depth    (code_depth)
    ) u_code_buf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .in_i     (code_u),
        .buffer_o (code_buf)
    );

    comb_ffe u_ffe (
        .codes_i           (adc_codes_i),
        .prev_codes_i      (prev_codes),
        .weights_i         (weights_i),
        .disable_product_i (disable_product_i),
        .ffe_shift_i       (ffe_shift_i),
        .estimate_o        (estimate)
    );

    comb_comp u_slicer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .estimate_i (estimate),
        .thresh_i   (thresh_i),
        .bits_o     (bits_o)
    );

    // Copy 0 feeds the channel filter, copies 1 and 2 line up with the errors
    delay_buffer #(
        .lanes    (lanes),
        .bitwidth (1),
        .depth    (bit_depth)
    ) u_bit_buf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .in_i     (bit_u),
        .buffer_o (bit_buf)
    );

    channel_filter u_chan (
        .bits_i          (bits_o),
        .prev_bits_i     (bits_d1),
        .channel_est_i   (channel_est_i),
        .channel_shift_i (channel_shift_i),
        .est_code_o      (est_code)
    );

    // Codes one cycle old match the bits now in the filter
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            err_next[i] = dsp_pkg::error_t'(est_code[i]) - dsp_pkg::error_t'(prev_codes[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lanes; i++) begin
                est_error_o[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lanes; i++) begin
                est_error_o[i] <= err_next[i];
            end
        end
    end

    delay_buffer #(
        .lanes    (lanes),
        .bitwidth (err_w),
        .depth    (err_depth)
    ) u_err_buf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .in_i     (err_u),
        .buffer_o (err_buf)
    );

    sliding_detector u_detector (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .errors_i      (est_error_o),
        .prev_errors_i (prev_err),
        .bits_i        (bits_d1),
        .prev_bits_i   (bits_d2),
        .channel_est_i (channel_est_i),
        .err_pos_o     (err_pos_o)
    );

endmodule : datapath_core

// ==== hw/sliding_detector.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module sliding_detector (
    input  logic            clk,
    input  logic            rst_n_i,
    input  dsp_pkg::error_t errors_i      [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::error_t prev_errors_i [`DSP_CHANNEL_WIDTH-1:0],
    input  logic            bits_i        [`DSP_CHANNEL_WIDTH-1:0],
    input  logic            prev_bits_i   [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::tap_t   channel_est_i [`DSP_CHANNEL_WIDTH-1:0][`DSP_CHANNEL_DEPTH-1:0],
    output logic [1:0]      err_pos_o     [`DSP_CHANNEL_WIDTH-1:0]
);

    localparam integer lanes   = `DSP_CHANNEL_WIDTH;
    localparam integer depth   = `DSP_CHANNEL_DEPTH;
    localparam integer seq_len = `DSP_SEQ_LENGTH;

    // Candidates: none, lane i, lanes i and i+1
    localparam integer num_cand = 3;

    // Two flips can move an error by four taps
    localparam integer adj_w  = `DSP_ERROR_PRECISION + 2;
    localparam integer sq_w   = 2 * adj_w;
    localparam integer cost_w = sq_w + $clog2(seq_len);

    dsp_pkg::error_t err_stream [2*lanes-1:0];
    logic            sym_stream [2*lanes-1:0];
    logic [1:0]      pos_next   [lanes-1:0];

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            err_stream[i]         = prev_errors_i[i];
            err_stream[lanes + i] = errors_i[i];
            sym_stream[i]         = prev_bits_i[i];
            sym_stream[lanes + i] = bits_i[i];
        end
    end

    always_comb begin
        logic signed [adj_w-1:0]  adj;
        logic signed [adj_w-1:0]  tap;
        logic signed [sq_w-1:0]   sq;
        logic signed [cost_w-1:0] cost;
        logic signed [cost_w-1:0] best_cost;
        logic [1:0]               best;

        for (int i = 0; i < lanes; i++) begin
            best      = 2'd0;
            best_cost = '0;
            for (int c = 0; c < num_cand; c++) begin
                cost = '0;
                for (int j = i; j < i + seq_len; j++) begin
                    adj = err_stream[j];
                    // Candidate c flips lanes i up to i+c-1
                    for (int m = i; m < i + c; m++) begin
                        if (j >= m && j - m < depth) begin
                            tap = channel_est_i[j % lanes][j - m];
                            if (sym_stream[m]) begin
                                adj = adj - (tap <<< 1);
                            end else begin
                                adj = adj + (tap <<< 1);
                            end
                        end
                    end
                    sq   = adj * adj;
                    cost = cost + sq;
                end
                // Strict compare keeps the lowest code on a tie
                if (c == 0 || cost < best_cost) begin
                    best_cost = cost;
                    best      = 2'(c);
                end
            end
            pos_next[i] = best;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lanes; i++) begin
                err_pos_o[i] <= 2'd0;
            end
        end else begin
            for (int i = 0; i < lanes; i++) begin
                err_pos_o[i] <= pos_next[i];
            end
        end
    end

endmodule : sliding_detector

// ==== hw/channel_filter.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module channel_filter (
    input  logic               bits_i          [`DSP_CHANNEL_WIDTH-1:0],
    input  logic               prev_bits_i     [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::tap_t      channel_est_i   [`DSP_CHANNEL_WIDTH-1:0][`DSP_CHANNEL_DEPTH-1:0],
    input  logic [`DSP_CHAN_SHIFT_PRECISION-1:0] channel_shift_i [`DSP_CHANNEL_WIDTH-1:0],
    output dsp_pkg::est_code_t est_code_o      [`DSP_CHANNEL_WIDTH-1:0]
);

    localparam integer lanes = `DSP_CHANNEL_WIDTH;
    localparam integer depth = `DSP_CHANNEL_DEPTH;
    localparam integer acc_w = `DSP_CHAN_PRECISION + $clog2(depth) + 1;

    logic sym_stream [2*lanes-1:0];

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            sym_stream[i]         = prev_bits_i[i];
            sym_stream[lanes + i] = bits_i[i];
        end
    end

    always_comb begin
        logic signed [acc_w-1:0] acc;
        logic signed [acc_w-1:0] tap;
        logic signed [acc_w-1:0] shifted;

        for (int i = 0; i < lanes; i++) begin
            acc = '0;
            for (int k = 0; k < depth; k++) begin
                tap = channel_est_i[i][k];
                // Bit 1 is symbol +1, bit 0 is symbol -1
                if (sym_stream[lanes + i - k]) begin
                    acc = acc + tap;
                end else begin
                    acc = acc - tap;
                end
            end
            shifted = acc >>> channel_shift_i[i];
            est_code_o[i] = shifted[`DSP_EST_CODE_PRECISION-1:0];
        end
    end

endmodule : channel_filter

// ==== hw/comb_comp.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module comb_comp (
    input  logic              clk,
    input  logic              rst_n_i,
    input  dsp_pkg::ffe_est_t estimate_i [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::ffe_est_t thresh_i   [`DSP_CHANNEL_WIDTH-1:0],
    output logic              bits_o     [`DSP_CHANNEL_WIDTH-1:0]
);

    localparam integer lanes = `DSP_CHANNEL_WIDTH;

    logic bits_next [lanes-1:0];

    // Signed compare, equal to threshold slices high
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            bits_next[i] = (estimate_i[i] >= thresh_i[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lanes; i++) begin
                bits_o[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < lanes; i++) begin
                bits_o[i] <= bits_next[i];
            end
        end
    end

endmodule : comb_comp

// ==== hw/comb_ffe.sv ====
`timescale 1ns/100ps
`include "dsp_config.svh"

module comb_ffe (
    input  dsp_pkg::code_t    codes_i           [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::code_t    prev_codes_i      [`DSP_CHANNEL_WIDTH-1:0],
    input  dsp_pkg::weight_t  weights_i         [`DSP_FFE_LENGTH-1:0][`DSP_CHANNEL_WIDTH-1:0],
    input  logic              disable_product_i [`DSP_FFE_LENGTH-1:0][`DSP_CHANNEL_WIDTH-1:0],
    input  logic [`DSP_FFE_SHIFT_PRECISION-1:0] ffe_shift_i [`DSP_CHANNEL_WIDTH-1:0],
    output dsp_pkg::ffe_est_t estimate_o        [`DSP_CHANNEL_WIDTH-1:0]
);

    localparam integer lanes = `DSP_CHANNEL_WIDTH;
    localparam integer taps  = `DSP_FFE_LENGTH;

    // Products at full width plus growth for the tap sum
    localparam integer acc_w = `DSP_CODE_PRECISION + `DSP_WEIGHT_PRECISION + $clog2(taps) + 1;

    dsp_pkg::code_t stream [2*lanes-1:0];

    // Previous word at the low indices, current word above it
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            stream[i]         = prev_codes_i[i];
            stream[lanes + i] = codes_i[i];
        end
    end

    always_comb begin
        logic signed [acc_w-1:0] acc;
        logic signed [acc_w-1:0] shifted;

        for (int i = 0; i < lanes; i++) begin
            acc = '0;
            for (int k = 0; k < taps; k++) begin
                // Tap k looks k lanes back in the joined stream
                if (!disable_product_i[k][i]) begin
                    acc = acc + weights_i[k][i] * stream[lanes + i - k];
                end
            end
            shifted = acc >>> ffe_shift_i[i];
            estimate_o[i] = shifted[`DSP_FFE_OUT_PRECISION-1:0];
        end
    end

endmodule : comb_ffe

// ==== hw/delay_buffer.sv ====
`timescale 1ns/100ps

module delay_buffer #(
    parameter integer lanes    = 4,
    parameter integer bitwidth = 8,
    parameter integer depth    = 1
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [bitwidth-1:0] in_i     [lanes-1:0],
    output logic [bitwidth-1:0] buffer_o [lanes-1:0][depth:0]
);

    logic [bitwidth-1:0] stage [lanes-1:0][depth:1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < lanes; i++) begin
                for (int d = 1; d <= depth; d++) begin
                    stage[i][d] <= '0;
                end
            end
        end else begin
            for (int i = 0; i < lanes; i++) begin
                stage[i][1] <= in_i[i];
                for (int d = 2; d <= depth; d++) begin
                    stage[i][d] <= stage[i][d-1];
                end
            end
        end
    end

    // Copy 0 is the live input
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            buffer_o[i][0] = in_i[i];
            for (int d = 1; d <= depth; d++) begin
                buffer_o[i][d] = stage[i][d];
            end
        end
    end

endmodule : delay_buffer

// ==== hw/dsp_pkg.sv ====
`include "dsp_config.svh"

package dsp_pkg;

    // Raw ADC sample
    typedef logic signed [`DSP_CODE_PRECISION-1:0] code_t;

    // FFE coefficient
    typedef logic signed [`DSP_WEIGHT_PRECISION-1:0] weight_t;

    // FFE output, also the slicer threshold
    typedef logic signed [`DSP_FFE_OUT_PRECISION-1:0] ffe_est_t;

    // Channel impulse response tap
    typedef logic signed [`DSP_CHAN_PRECISION-1:0] tap_t;

    // Code rebuilt from the sliced bits
    typedef logic signed [`DSP_EST_CODE_PRECISION-1:0] est_code_t;

    // Rebuilt code minus ADC code
    typedef logic signed [`DSP_ERROR_PRECISION-1:0] error_t;

endpackage

// ==== hw/dsp_config.svh ====
`ifndef DSP_CONFIG_SVH
`define DSP_CONFIG_SVH

// Lanes per parallel word
`define DSP_CHANNEL_WIDTH 4

// ADC input codes
`define DSP_CODE_PRECISION 8

// Feed-forward equalizer
`define DSP_FFE_LENGTH 3
`define DSP_WEIGHT_PRECISION 8
`define DSP_FFE_SHIFT_PRECISION 4
`define DSP_FFE_OUT_PRECISION 10

// Channel model used to rebuild the codes
`define DSP_CHANNEL_DEPTH 3
`define DSP_CHAN_PRECISION 8
`define DSP_CHAN_SHIFT_PRECISION 3
`define DSP_EST_CODE_PRECISION 10

// Error and detector window
`define DSP_ERROR_PRECISION 11
`define DSP_SEQ_LENGTH 4

`endif
